//--- verilog/acc_pkg.sv
// Shared types for the accelerator path. Opcode sits in insn[2:0], and only 8 transaction IDs exist
`default_nettype none

package acc_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Scoreboard size and transaction ID width
  localparam int unsigned SB_ENTRIES    = 8;
  localparam int unsigned TRANS_ID_BITS = 3;

  // Illegal instruction cause as seen by the trap logic
  localparam logic [4:0] CAUSE_ILLEGAL_INSTR = 5'd2;

  // Opcode in the low three bits of the instruction word
  // Values 5 to 7 have no operation behind them
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_XOR = 3'd2,
    OP_AND = 3'd3,
    OP_MUL = 3'd4
  } acc_op_e;

  // Issue stage payload
  typedef struct packed {
    logic [31:0]              insn;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } acc_issue_t;

  // Request towards the accelerator
  typedef struct packed {
    logic [31:0]              insn;
    logic [XLEN-1:0]          rs1;
    logic [XLEN-1:0]          rs2;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } acc_req_t;

  // Accelerator answer
  // error set means the opcode was not understood
  typedef struct packed {
    logic [XLEN-1:0]          result;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic                     error;
  } acc_resp_t;

  // Exception handed back to the commit stage
  typedef struct packed {
    logic [4:0]      cause;
    logic [XLEN-1:0] tval;
    logic            valid;
  } exception_t;

endpackage

`default_nettype wire

//--- verilog/acc_insn_queue.sv
// Fall-through FIFO. Push when full and pop when empty are illegal, and flush wins over a push
`timescale 1ns/10ps
`default_nettype none

module acc_insn_queue #(
  parameter int unsigned DEPTH = 3,
  parameter type         dtype = logic
) (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,
  input  wire logic                     flush_i,
  input  wire logic                     push_i,
  input  wire dtype                     data_i,
  input  wire logic                     pop_i,
  output dtype                          data_o,
  output logic                          empty_o,
  output logic [$clog2(DEPTH+1)-1:0]    usage_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  dtype             mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push_ok;
  logic             pop_ok;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign push_ok = push_i && !full;
  // Empty queue lets the pushed word through the same cycle
  assign empty_o = (count_q == '0) && !push_i;
  assign pop_ok  = pop_i && !empty_o;
  assign data_o  = (count_q == '0) ? data_i : mem_q[rd_ptr_q];
  assign usage_o = count_q;

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        // Wrap at the last slot, DEPTH need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_ok) - CNT_W'(pop_ok);
    end
  end

  // Storage
  // A fall-through push still lands here but the read pointer skips it
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Issuer must respect the ready it was given
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && full && !flush_i))
    else $error("push into full instruction queue");

  // Consumer pops only what it has seen
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(pop_i && empty_o))
    else $error("pop from empty instruction queue");

endmodule

`default_nettype wire

//--- verilog/acc_spec_tracker.sv
// Pending and ready bits per transaction ID. IDs must be unique among instructions in flight
`timescale 1ns/10ps
`default_nettype none

module acc_spec_tracker import acc_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,
  input  wire logic                     flush_i,
  input  wire logic                     push_i,
  input  wire logic [TRANS_ID_BITS-1:0] push_trans_id_i,
  input  wire logic                     commit_i,
  input  wire logic [TRANS_ID_BITS-1:0] commit_trans_id_i,
  input  wire logic                     issue_i,
  input  wire logic [TRANS_ID_BITS-1:0] issue_trans_id_i,
  input  wire logic [TRANS_ID_BITS-1:0] head_trans_id_i,
  output logic                          head_ready_o
);

  logic [SB_ENTRIES-1:0] pending_d, pending_q;
  logic [SB_ENTRIES-1:0] ready_d, ready_q;
  logic                  commit_hit;

  // Commit only counts for an ID we actually hold
  assign commit_hit = commit_i && pending_q[commit_trans_id_i];

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    // New speculative instruction
    if (push_i) begin
      pending_d[push_trans_id_i] = 1'b1;
    end
    // Uncommitted IDs are forgotten, ready ones stay
    if (flush_i) begin
      pending_d = '0;
    end
    // Reached commit so no longer speculative
    if (commit_hit) begin
      pending_d[commit_trans_id_i] = 1'b0;
      ready_d[commit_trans_id_i]   = 1'b1;
    end
    // Left the queue, later than the commit on purpose
    if (issue_i) begin
      ready_d[issue_trans_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

  // Head may go out in its own commit cycle
  assign head_ready_o = ready_q[head_trans_id_i] ||
                        (commit_hit && (commit_trans_id_i == head_trans_id_i));

  // Commit stage should only name IDs that went through the dispatcher
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_i |-> (pending_q[commit_trans_id_i] || ready_q[commit_trans_id_i]))
    else $warning("commit on unknown transaction ID %0d", commit_trans_id_i);

endmodule

`default_nettype wire

//--- verilog/acc_req_register.sv
// One-entry fall-through register. It takes no new request while it holds one
`timescale 1ns/10ps
`default_nettype none

module acc_req_register import acc_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire logic     valid_i,
  output logic          ready_o,
  input  wire acc_req_t data_i,
  output logic          valid_o,
  input  wire logic     ready_i,
  output acc_req_t      data_o
);

  logic     full_q;
  acc_req_t data_q;

  // Empty register is transparent
  assign valid_o = full_q || valid_i;
  assign data_o  = full_q ? data_q : data_i;
  assign ready_o = !full_q;

  // Occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Held request drains once the far side takes it
      if (ready_i) begin
        full_q <= 1'b0;
      end
    end else if (valid_i && !ready_i) begin
      full_q <= 1'b1;
    end
  end

  // Capture a blocked request
  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

  // Accelerator sees a steady request until it takes it
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("request changed while stalled");

endmodule

`default_nettype wire

//--- verilog/acc_dispatcher.sv
// Dispatch of non-speculative instructions in order. One response per request and no response ready
`timescale 1ns/10ps
`default_nettype none

module acc_dispatcher import acc_pkg::*; #(
  parameter int unsigned QUEUE_DEPTH = 3
) (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,
  input  wire logic                     flush_i,
  // Issue stage
  input  wire logic                     acc_valid_i,
  input  wire acc_issue_t               acc_data_i,
  output logic                          acc_ready_o,
  // Commit stage
  input  wire logic                     acc_commit_i,
  input  wire logic [TRANS_ID_BITS-1:0] acc_commit_trans_id_i,
  // Writeback
  output logic                          acc_valid_o,
  output logic [TRANS_ID_BITS-1:0]      acc_trans_id_o,
  output logic [XLEN-1:0]               acc_result_o,
  output exception_t                    acc_exception_o,
  // Accelerator
  output acc_req_t                      acc_req_o,
  output logic                          acc_req_valid_o,
  input  wire logic                     acc_req_ready_i,
  input  wire acc_resp_t                acc_resp_i,
  input  wire logic                     acc_resp_valid_i
);

  localparam int unsigned USAGE_W = $clog2(QUEUE_DEPTH + 1);

  acc_issue_t         queue_head;
  logic               queue_pop;
  logic               queue_empty;
  logic [USAGE_W-1:0] queue_usage;
  logic               head_ready;
  acc_req_t           acc_req;
  logic               acc_req_valid;
  logic               acc_req_ready;

  // Instruction queue
  acc_insn_queue #(
    .DEPTH (QUEUE_DEPTH),
    .dtype (acc_issue_t)
  ) i_acc_insn_queue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .push_i   (acc_valid_i),
    .data_i   (acc_data_i),
    .pop_i    (queue_pop),
    .data_o   (queue_head),
    .empty_o  (queue_empty),
    .usage_o  (queue_usage)
  );

  // Keep one slot spare so a push in flight always fits
  assign acc_ready_o = queue_usage < USAGE_W'(QUEUE_DEPTH - 1);

  // Tracks which IDs have reached commit
  acc_spec_tracker i_acc_spec_tracker (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .flush_i           (flush_i),
    .push_i            (acc_valid_i),
    .push_trans_id_i   (acc_data_i.trans_id),
    .commit_i          (acc_commit_i),
    .commit_trans_id_i (acc_commit_trans_id_i),
    .issue_i           (queue_pop),
    .issue_trans_id_i  (queue_head.trans_id),
    .head_trans_id_i   (queue_head.trans_id),
    .head_ready_o      (head_ready)
  );

  // Queue head repacked as a request
  assign acc_req = '{
    insn:     queue_head.insn,
    rs1:      queue_head.operand_a,
    rs2:      queue_head.operand_b,
    trans_id: queue_head.trans_id
  };

  // Offered only once it is no longer speculative
  assign acc_req_valid = !queue_empty && head_ready;
  assign queue_pop     = acc_req_valid && acc_req_ready;

  acc_req_register i_acc_req_register (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (acc_req_valid),
    .ready_o  (acc_req_ready),
    .data_i   (acc_req),
    .valid_o  (acc_req_valid_o),
    .ready_i  (acc_req_ready_i),
    .data_o   (acc_req_o)
  );

  // Response goes straight to writeback
  assign acc_valid_o     = acc_resp_valid_i;
  assign acc_trans_id_o  = acc_resp_i.trans_id;
  assign acc_result_o    = acc_resp_i.result;
  // Any accelerator error is an illegal instruction
  assign acc_exception_o = '{
    cause: CAUSE_ILLEGAL_INSTR,
    tval:  '0,
    valid: acc_resp_i.error
  };

endmodule

`default_nettype wire

//--- verilog/acc_int_accel.sv
// Toy integer unit. One request at a time, ALU ops answer in 1 cycle and MUL in 4 cycles
`timescale 1ns/10ps
`default_nettype none

module acc_int_accel import acc_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire acc_req_t req_i,
  input  wire logic     req_valid_i,
  output logic          req_ready_o,
  output acc_resp_t     resp_o,
  output logic          resp_valid_o
);

  acc_op_e                  op;
  logic                     accept;
  logic                     mul_accept;
  logic                     mul_last;
  logic                     busy_q;
  logic [1:0]               step_q;
  logic [XLEN-1:0]          mul_a_q, mul_b_q, mul_acc_q;
  logic [XLEN-1:0]          mul_a_in, mul_b_in, mul_acc_in, mul_sum;
  logic [TRANS_ID_BITS-1:0] mul_id_q;
  logic [XLEN-1:0]          alu_result;
  logic                     alu_error;
  acc_resp_t                resp_q;
  logic                     resp_valid_q;

  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && req_ready_o;
  assign op          = acc_op_e'(req_i.insn[2:0]);
  assign mul_accept  = accept && (op == OP_MUL);
  // Fourth partial product is being added
  assign mul_last    = busy_q && (step_q == 2'd3);

  // Single-cycle ops, unknown opcodes flagged
  always_comb begin
    alu_error = 1'b0;
    case (op)
      OP_ADD:  alu_result = req_i.rs1 + req_i.rs2;
      OP_SUB:  alu_result = req_i.rs1 - req_i.rs2;
      OP_XOR:  alu_result = req_i.rs1 ^ req_i.rs2;
      OP_AND:  alu_result = req_i.rs1 & req_i.rs2;
      default: begin
        alu_result = '0;
        alu_error  = 1'b1;
      end
    endcase
  end

  // Radix-256 shift-add, first byte taken at acceptance
  always_comb begin
    if (mul_accept) begin
      mul_a_in   = req_i.rs1;
      mul_b_in   = req_i.rs2;
      mul_acc_in = '0;
    end else begin
      mul_a_in   = mul_a_q;
      mul_b_in   = mul_b_q;
      mul_acc_in = mul_acc_q;
    end
    // Low XLEN bits only
    mul_sum = mul_acc_in + mul_a_in * XLEN'(mul_b_in[7:0]);
  end

  // Control
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q       <= 1'b0;
      step_q       <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= accept && !mul_accept;
      if (mul_accept) begin
        busy_q <= 1'b1;
        step_q <= 2'd1;
      end else if (busy_q) begin
        step_q <= step_q + 2'd1;
        if (mul_last) begin
          busy_q       <= 1'b0;
          resp_valid_q <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    if (mul_accept || busy_q) begin
      mul_acc_q <= mul_sum;
      mul_a_q   <= mul_a_in << 8;
      mul_b_q   <= mul_b_in >> 8;
    end
    if (mul_accept) begin
      mul_id_q <= req_i.trans_id;
    end
    if (accept && !mul_accept) begin
      resp_q <= '{result: alu_result, trans_id: req_i.trans_id, error: alu_error};
    end else if (mul_last) begin
      resp_q <= '{result: mul_sum, trans_id: mul_id_q, error: 1'b0};
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  // Multiply latency is fixed at four cycles
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mul_accept |-> ##4 resp_valid_o)
    else $error("multiply response not 4 cycles after acceptance");

endmodule

`default_nettype wire

//--- verilog/acc_subsystem.sv
// Dispatcher joined to the toy integer accelerator. Commits must come in issue order
`timescale 1ns/10ps
`default_nettype none

module acc_subsystem import acc_pkg::*; #(
  parameter int unsigned QUEUE_DEPTH = 3
) (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,
  input  wire logic                     flush_i,
  input  wire logic                     acc_valid_i,
  input  wire acc_issue_t               acc_data_i,
  output logic                          acc_ready_o,
  input  wire logic                     acc_commit_i,
  input  wire logic [TRANS_ID_BITS-1:0] acc_commit_trans_id_i,
  output logic                          acc_valid_o,
  output logic [TRANS_ID_BITS-1:0]      acc_trans_id_o,
  output logic [XLEN-1:0]               acc_result_o,
  output exception_t                    acc_exception_o
);

  // Request and response between the two blocks
  acc_req_t  acc_req;
  logic      acc_req_valid;
  logic      acc_req_ready;
  acc_resp_t acc_resp;
  logic      acc_resp_valid;

  acc_dispatcher #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_acc_dispatcher (
    .clk_i                 (clk_i),
    .arst_n_i              (arst_n_i),
    .flush_i               (flush_i),
    .acc_valid_i           (acc_valid_i),
    .acc_data_i            (acc_data_i),
    .acc_ready_o           (acc_ready_o),
    .acc_commit_i          (acc_commit_i),
    .acc_commit_trans_id_i (acc_commit_trans_id_i),
    .acc_valid_o           (acc_valid_o),
    .acc_trans_id_o        (acc_trans_id_o),
    .acc_result_o          (acc_result_o),
    .acc_exception_o       (acc_exception_o),
    .acc_req_o             (acc_req),
    .acc_req_valid_o       (acc_req_valid),
    .acc_req_ready_i       (acc_req_ready),
    .acc_resp_i            (acc_resp),
    .acc_resp_valid_i      (acc_resp_valid)
  );

  acc_int_accel i_acc_int_accel (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (acc_req),
    .req_valid_i  (acc_req_valid),
    .req_ready_o  (acc_req_ready),
    .resp_o       (acc_resp),
    .resp_valid_o (acc_resp_valid)
  );

endmodule

`default_nettype wire

//--- testbench/acc_tb.sv
// Directed tests for acc_subsystem with QUEUE_DEPTH 3. Expects in-order commits and unique IDs in flight
`timescale 1ns/10ps
`default_nettype none

module acc_tb import acc_pkg::*; ();

  localparam int unsigned QUEUE_DEPTH  = 3;
  localparam int unsigned CLK_PERIOD   = 10;
  localparam int unsigned NUM_TESTS    = 5;
  // Worst case per test, the longest one needs well under this
  localparam int unsigned TEST_CYCLES  = 200;
  localparam int unsigned RESP_TIMEOUT = 20;

  logic                     clk;
  logic                     arst_n;
  logic                     flush;
  logic                     acc_valid_in;
  acc_issue_t               acc_data;
  logic                     acc_ready;
  logic                     acc_commit;
  logic [TRANS_ID_BITS-1:0] acc_commit_trans_id;
  logic                     acc_valid_out;
  logic [TRANS_ID_BITS-1:0] acc_trans_id;
  logic [XLEN-1:0]          acc_result;
  exception_t               acc_exception;

  // Free running cycle count, read at falling edges only
  int unsigned              cycle = 0;
  int unsigned              commit_cycle [SB_ENTRIES];
  logic [31:0]              lcg_state;
  logic [TRANS_ID_BITS-1:0] next_id;
  int                       errors;
  int                       tests_failed;

  acc_subsystem #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dut_i (
    .clk_i                 (clk),
    .arst_n_i              (arst_n),
    .flush_i               (flush),
    .acc_valid_i           (acc_valid_in),
    .acc_data_i            (acc_data),
    .acc_ready_o           (acc_ready),
    .acc_commit_i          (acc_commit),
    .acc_commit_trans_id_i (acc_commit_trans_id),
    .acc_valid_o           (acc_valid_out),
    .acc_trans_id_o        (acc_trans_id),
    .acc_result_o          (acc_result),
    .acc_exception_o       (acc_exception)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Ends a run that hangs
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, tests did not finish", NUM_TESTS * TEST_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  // Operand source
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // IDs handed out in issue order, wrapping at 8
  function automatic logic [TRANS_ID_BITS-1:0] take_id();
    logic [TRANS_ID_BITS-1:0] id;
    id      = next_id;
    next_id = next_id + 1'b1;
    return id;
  endfunction

  // Opcode rule, low XLEN bits only, illegal ops give zero
  function automatic logic [XLEN-1:0] model_result(input logic [2:0] op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      OP_AND:  return a & b;
      OP_MUL:  return a * b;
      default: return '0;
    endcase
  endfunction

  task automatic check_result(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_trans_id(input logic [TRANS_ID_BITS-1:0] got,
                                input logic [TRANS_ID_BITS-1:0] exp);
    if (got !== exp) begin
      $display("FAILED acc_trans_id_o: got %h, expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_exception(input exception_t got, input exception_t exp);
    if (got !== exp) begin
      $display("FAILED acc_exception_o: got %h, expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Push one instruction once the issue port shows room the cycle before
  task automatic issue_insn(input logic [31:0] insn, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [TRANS_ID_BITS-1:0] id);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!acc_ready && waited < RESP_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!acc_ready) begin
      $display("Issue port stayed busy, instruction with ID %0d was not pushed", id);
      errors++;
      @(posedge clk);
    end else begin
      @(posedge clk);
      acc_valid_in <= 1'b1;
      acc_data     <= '{insn: insn, operand_a: a, operand_b: b, trans_id: id};
      @(posedge clk);
      acc_valid_in <= 1'b0;
    end
  endtask

  // Called right after a rising edge, so back-to-back calls give back-to-back strobes
  task automatic commit_insn(input logic [TRANS_ID_BITS-1:0] id);
    acc_commit          <= 1'b1;
    acc_commit_trans_id <= id;
    @(negedge clk);
    commit_cycle[id] = cycle;
    @(posedge clk);
    acc_commit <= 1'b0;
  endtask

  task automatic pulse_flush();
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  // Waits for the next result and checks it and its distance from the commit
  task automatic expect_response(input logic [TRANS_ID_BITS-1:0] id,
                                 input logic [XLEN-1:0] exp_result,
                                 input logic exp_error, input int unsigned exp_latency);
    int unsigned waited;
    exception_t  exp_exc;
    waited  = 0;
    exp_exc = '{cause: CAUSE_ILLEGAL_INSTR, tval: '0, valid: exp_error};
    @(negedge clk);
    while (!acc_valid_out && waited < RESP_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!acc_valid_out) begin
      $display("No response for transaction ID %0d within %0d cycles", id, RESP_TIMEOUT);
      errors++;
    end else begin
      if (cycle - commit_cycle[id] != exp_latency) begin
        $display("Response for transaction ID %0d came %0d cycles after commit, expected %0d",
                 id, cycle - commit_cycle[id], exp_latency);
        errors++;
      end
      check_trans_id(acc_trans_id, id);
      check_result("acc_result_o", acc_result, exp_result);
      check_exception(acc_exception, exp_exc);
    end
    @(posedge clk);
  endtask

  // No result may show up for a while
  task automatic expect_quiet(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_flag("acc_valid_o", acc_valid_out, 1'b0);
    end
    @(posedge clk);
  endtask

  // Push, commit straight away and check against the opcode rule
  task automatic run_single(input logic [2:0] op);
    logic [31:0]              word;
    logic [XLEN-1:0]          a;
    logic [XLEN-1:0]          b;
    logic [TRANS_ID_BITS-1:0] id;
    word = lcg_next();
    a    = lcg_next();
    b    = lcg_next();
    id   = take_id();
    issue_insn({word[31:3], op}, a, b, id);
    commit_insn(id);
    // Opcodes above MUL are illegal, MUL needs 4 cycles and the rest 1
    expect_response(id, model_result(op, a, b), op > 3'd4, (op == OP_MUL) ? 4 : 1);
  endtask

  task automatic alu_results_test();
    for (int i = 0; i < 4; i++) begin
      run_single(3'(i));
    end
  endtask

  task automatic spec_hold_test();
    logic [XLEN-1:0]          a;
    logic [XLEN-1:0]          b;
    logic [TRANS_ID_BITS-1:0] id;
    a  = lcg_next();
    b  = lcg_next();
    id = take_id();
    issue_insn({29'd0, OP_XOR}, a, b, id);
    // Still speculative, nothing may reach the accelerator
    expect_quiet(6);
    commit_insn(id);
    expect_response(id, a ^ b, 1'b0, 1);
  endtask

  task automatic mul_backpressure_test();
    logic [XLEN-1:0]          mul_a;
    logic [XLEN-1:0]          mul_b;
    logic [XLEN-1:0]          add_a;
    logic [XLEN-1:0]          add_b;
    logic [TRANS_ID_BITS-1:0] mul_id;
    logic [TRANS_ID_BITS-1:0] add_id;
    mul_a  = lcg_next();
    mul_b  = lcg_next();
    add_a  = lcg_next();
    add_b  = lcg_next();
    mul_id = take_id();
    add_id = take_id();
    issue_insn({29'd0, OP_MUL}, mul_a, mul_b, mul_id);
    issue_insn({29'd0, OP_ADD}, add_a, add_b, add_id);
    // Two entries held, one slot kept spare
    repeat (2) begin
      @(negedge clk);
      check_flag("acc_ready_o", acc_ready, 1'b0);
    end
    @(posedge clk);
    commit_insn(mul_id);
    commit_insn(add_id);
    expect_response(mul_id, mul_a * mul_b, 1'b0, 4);
    // ADD waits in the request register and answers the cycle after MUL
    expect_response(add_id, add_a + add_b, 1'b0, 4);
  endtask

  task automatic illegal_opcode_test();
    for (int i = 5; i < 8; i++) begin
      run_single(3'(i));
    end
  endtask

  task automatic flush_test();
    logic [TRANS_ID_BITS-1:0] first_id;
    logic [TRANS_ID_BITS-1:0] second_id;
    first_id  = take_id();
    second_id = take_id();
    issue_insn({29'd0, OP_ADD}, lcg_next(), lcg_next(), first_id);
    issue_insn({29'd0, OP_SUB}, lcg_next(), lcg_next(), second_id);
    pulse_flush();
    // Both IDs were forgotten, their commits must go nowhere
    commit_insn(first_id);
    commit_insn(second_id);
    expect_quiet(8);
    @(negedge clk);
    check_flag("acc_ready_o", acc_ready, 1'b1);
    @(posedge clk);
    run_single(OP_AND);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  initial begin
    int mark;
    arst_n              = 1'b0;
    flush               = 1'b0;
    acc_valid_in        = 1'b0;
    acc_data            = '0;
    acc_commit          = 1'b0;
    acc_commit_trans_id = '0;
    lcg_state           = 32'h6c87f0fc;
    next_id             = '0;
    errors              = 0;
    tests_failed        = 0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    // Idle state out of reset
    @(negedge clk);
    check_flag("acc_valid_o", acc_valid_out, 1'b0);
    check_flag("acc_ready_o", acc_ready, 1'b1);
    @(posedge clk);

    mark = errors;
    alu_results_test();
    report_test("alu_results", mark);
    mark = errors;
    spec_hold_test();
    report_test("spec_hold", mark);
    mark = errors;
    mul_backpressure_test();
    report_test("mul_backpressure", mark);
    mark = errors;
    illegal_opcode_test();
    report_test("illegal_opcode", mark);
    mark = errors;
    flush_test();
    report_test("flush", mark);

    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/acc_pkg.sv
verilog/acc_insn_queue.sv
verilog/acc_spec_tracker.sv
verilog/acc_req_register.sv
verilog/acc_dispatcher.sv
verilog/acc_int_accel.sv
verilog/acc_subsystem.sv
testbench/acc_tb.sv

//--- Makefile
# Verilator flow for the accelerator dispatch subsystem
TOP := acc_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f sim.f --top-module $(TOP)
	verilator --lint-only --assert --timescale 1ns/10ps -f sim.f --top-module acc_subsystem

$(OBJ)/V$(TOP): sim.f $(wildcard verilog/*.sv testbench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps -f sim.f \
		--top-module $(TOP) -Mdir $(OBJ)

sim: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf $(OBJ) sim.log
